/* bench/axi_read_master_chk.sv */
// Address channel hold and vacancy range assertions, bound to the address issue block
module axi_read_master_chk
  import rd_master_pkg::*;
(
  input logic                     aclk,
  input logic                     areset,
  input logic                     arvalid,
  input logic                     arready,
  input addr_t                    araddr,
  input arlen_t                   arlen,
  input logic [outstanding_w-1:0] vacancy
);

  // Failures seen so far, watched from the testbench
  int error_count = 0;

  //////////////////////////////
  // Address channel
  //////////////////////////////

  // A raised request waits for the slave
  ar_hold_valid: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid)
    else begin
      error_count = error_count + 1;
      $error("arvalid dropped before arready");
    end

  // Address and length frozen while waiting
  ar_hold_payload: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> $stable(araddr) && $stable(arlen))
    else begin
      error_count = error_count + 1;
      $error("araddr or arlen changed before arready");
    end

  //////////////////////////////
  // Outstanding limit
  //////////////////////////////

  vacancy_range: assert property (@(posedge aclk) disable iff (areset)
    vacancy <= outstanding_w'(max_outstanding))
    else begin
      error_count = error_count + 1;
      $error("vacancy count above the outstanding limit");
    end

endmodule

bind ar_issue axi_read_master_chk ar_chk_inst (
  .aclk    (aclk),
  .areset  (areset),
  .arvalid (arvalid),
  .arready (arready),
  .araddr  (araddr),
  .arlen   (arlen),
  .vacancy (vacancy)
);

/* bench/axi_read_master_tb.sv */
// Read master testbench with clock, reset, memory slave model, stream model and checks
module axi_read_master_tb
  import rd_master_pkg::*;
();

  localparam int    num_xfers      = 12;
  localparam int    max_size_bytes = 6000;
  // Worst case four cycles per word, plus slack for setup and idle time
  localparam int    timeout_cycles = num_xfers * max_size_bytes / dw_bytes * 4 + 5000;
  // Memory word at a byte address holds that address plus this tag
  localparam data_t data_tag       = 32'h1357_0000;

  logic                   aclk;
  logic                   areset;
  logic                   ctrl_start;
  logic                   ctrl_done;
  addr_t                  ctrl_addr_offset;
  logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes;
  logic                   arvalid;
  logic                   arready;
  addr_t                  araddr;
  arlen_t                 arlen;
  logic                   rvalid;
  logic                   rready;
  data_t                  rdata;
  logic                   rlast;
  logic                   tvalid;
  logic                   tready;
  data_t                  tdata;
  logic                   tlast;

  // Model queues, requests and stream words in order
  addr_t  exp_addr_q[$];
  int     exp_len_q[$];
  data_t  exp_data_q[$];
  bit     exp_last_q[$];
  bit     exp_final_q[$];
  // Slave side, accepted requests still returning data
  addr_t  slave_addr_q[$];
  arlen_t slave_len_q[$];
  int     beat_index  = 0;
  int     outstanding = 0;
  int     done_count  = 0;
  int     cycle_count = 0;

  addr_t  offsets [num_xfers];
  int     sizes [num_xfers];

  axi_read_master axi_read_master_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
    end
  endtask

  // Request list and stream words of one transfer
  task automatic add_expected(input addr_t offset, input int size);
    int    words;
    int    bursts;
    int    len;
    addr_t base;
    addr_t addr;
    words  = (size + dw_bytes - 1) / dw_bytes;
    bursts = (words + burst_len - 1) / burst_len;
    base   = offset & ~addr_t'(burst_bytes - 1);
    for (int b = 0; b < bursts; b++) begin
      addr = base + addr_t'(b * burst_bytes);
      // Only the last burst may be short
      len  = (b == bursts - 1) ? words - b * burst_len : burst_len;
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(len - 1);
      for (int k = 0; k < len; k++) begin
        exp_data_q.push_back(addr + addr_t'(k * dw_bytes) + data_tag);
        exp_last_q.push_back(k == len - 1);
        exp_final_q.push_back((b == bursts - 1) && (k == len - 1));
      end
    end
  endtask

  // Random slave and sink handshakes, new values each falling edge
  task automatic drive_bus_inputs();
    forever begin
      @(negedge aclk);
      arready = ($urandom % 2) != 0;
      tready  = ($urandom % 4) != 0;
      if (slave_addr_q.size() != 0 && ($urandom % 4) != 0) begin
        rvalid = 1'b1;
        rdata  = slave_addr_q[0] + data_t'(beat_index * dw_bytes) + data_tag;
        rlast  = (beat_index == slave_len_q[0]);
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  always @(posedge aclk) begin
    logic done_expected;
    done_expected = 1'b0;
    cycle_count   = cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      stop_with_error("Timeout: the transfers did not finish, the run hung");
    end else if (axi_read_master_inst.ar_issue_inst.ar_chk_inst.error_count != 0) begin
      stop_with_error("An address channel assertion failed");
    end else if (!areset) begin
      check_value("rready", rready, 1'b1);
      // Address channel against the model request list
      if (arvalid && arready) begin
        if (exp_addr_q.size() == 0) begin
          stop_with_error("Address request arrived when none was expected");
        end else begin
          check_value("araddr", araddr, exp_addr_q.pop_front());
          check_value("arlen", arlen, exp_len_q.pop_front());
          slave_addr_q.push_back(araddr);
          slave_len_q.push_back(arlen);
          outstanding = outstanding + 1;
        end
      end
      // Slave steps through its burst
      if (rvalid && rready) begin
        if (rlast) begin
          void'(slave_addr_q.pop_front());
          void'(slave_len_q.pop_front());
          beat_index = 0;
        end else begin
          beat_index = beat_index + 1;
        end
      end
      // Stream words in order
      if (tvalid && tready) begin
        if (exp_data_q.size() == 0) begin
          stop_with_error("Stream word arrived when none was expected");
        end else begin
          check_value("tdata", tdata, exp_data_q.pop_front());
          check_value("tlast", tlast, exp_last_q.pop_front());
          done_expected = exp_final_q.pop_front();
          if (tlast) begin
            outstanding = outstanding - 1;
          end
        end
      end
      // Done only with the final tlast handshake
      check_value("ctrl_done", ctrl_done, done_expected);
      if (ctrl_done) begin
        done_count = done_count + 1;
      end
      if (outstanding > max_outstanding) begin
        stop_with_error($sformatf("More than %0d bursts were outstanding", max_outstanding));
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'hf52d_f525));
    for (int i = 0; i < num_xfers; i++) begin
      offsets[i] = $urandom;
      sizes[i]   = 1 + ($urandom % max_size_bytes);
    end
    // Largest size at least once, six bursts
    sizes[0] = max_size_bytes;

    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    arready                 = 1'b0;
    rvalid                  = 1'b0;
    rdata                   = '0;
    rlast                   = 1'b0;
    tready                  = 1'b0;
    fork
      drive_bus_inputs();
    join_none

    repeat (4) @(negedge aclk);
    areset = 1'b0;

    // Quiet outputs before any start
    repeat (3) begin
      @(posedge aclk);
      check_value("arvalid", arvalid, 1'b0);
      check_value("tvalid", tvalid, 1'b0);
      check_value("ctrl_done", ctrl_done, 1'b0);
    end

    for (int i = 0; i < num_xfers; i++) begin
      @(negedge aclk);
      add_expected(offsets[i], sizes[i]);
      ctrl_start              = 1'b1;
      ctrl_addr_offset        = offsets[i];
      ctrl_xfer_size_in_bytes = sizes[i];
      @(negedge aclk);
      ctrl_start = 1'b0;
      wait (done_count > i);
    end

    // Idle time to catch stray done pulses or words
    repeat (20) @(posedge aclk);
    if (exp_data_q.size() != 0 || exp_addr_q.size() != 0) begin
      stop_with_error("Expected requests or stream words never arrived");
    end else if (axi_read_master_inst.ar_issue_inst.ar_chk_inst.error_count != 0) begin
      stop_with_error("An address channel assertion failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* logic/ar_issue.sv */
// Read address request issue with address stepping and outstanding limit
module ar_issue
  import rd_master_pkg::*;
(
  input  logic       aclk,
  input  logic       areset,
  input  logic       start,
  input  addr_t      base_addr,
  input  txn_count_t num_txn,
  input  arlen_t     final_len,
  input  logic       single_txn,
  input  logic       burst_done,
  output logic       arvalid,
  input  logic       arready,
  output addr_t      araddr,
  output arlen_t     arlen
);

  logic                     ar_idle;
  logic                     arxfer;
  logic                     ar_done;
  logic                     ar_final;
  logic                     stall_ar;

  // Free outstanding slots
  logic [outstanding_w-1:0] vacancy;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign arxfer  = arvalid & arready;
  assign ar_done = ar_final & arxfer;

  // Idle until start, idle again once the last burst is taken
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (start) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // Raise only from low, so one idle cycle sits between requests
  // Once raised, hold until the slave accepts
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (!arvalid) begin
      arvalid <= ~ar_idle & ~stall_ar;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  //////////////////////////////
  // Address and length
  //////////////////////////////

  // One burst step per accepted request
  always_ff @(posedge aclk) begin
    if (start) begin
      araddr <= base_addr;
    end else if (arxfer) begin
      araddr <= araddr + addr_t'(burst_bytes);
    end
  end

  // Only the final burst can be short
  assign arlen = (ar_final || single_txn) ? final_len : arlen_t'(burst_len - 1);

  //////////////////////////////
  // Counters
  //////////////////////////////

  // Bursts still to request, zero marks the final one
  xfer_counter #(
    .width      (txn_cntr_w),
    .init_value ('0)
  ) txn_cntr_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (num_txn),
    .count      (),
    .is_zero    (ar_final)
  );

  // Free slots for bursts in flight
  // Empty means stall, a finished burst on the stream frees one
  xfer_counter #(
    .width      (outstanding_w),
    .init_value (outstanding_w'(max_outstanding))
  ) vacancy_cntr_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_done),
    .decr       (arxfer),
    .load_value ('0),
    .count      (vacancy),
    .is_zero    (stall_ar)
  );

endmodule

/* logic/axi_read_master.sv */
// Read master top with request setup, address issue, data FIFO and completion
module axi_read_master
  import rd_master_pkg::*;
(
  input  logic                   aclk,
  input  logic                   areset,

  // Control
  input  logic                   ctrl_start,
  output logic                   ctrl_done,
  input  addr_t                  ctrl_addr_offset,
  input  logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes,

  // Read address channel
  output logic                   arvalid,
  input  logic                   arready,
  output addr_t                  araddr,
  output arlen_t                 arlen,

  // Read data channel
  input  logic                   rvalid,
  output logic                   rready,
  input  data_t                  rdata,
  input  logic                   rlast,

  // Output stream
  output logic                   tvalid,
  input  logic                   tready,
  output data_t                  tdata,
  output logic                   tlast
);

  // Setup results, stable for the whole transfer
  logic       start;
  addr_t      base_addr;
  txn_count_t num_txn;
  arlen_t     final_len;
  logic       single_txn;

  // Stream side frees outstanding slots
  logic       burst_done;

  //////////////////////////////
  // Request path
  //////////////////////////////

  rd_request_setup rd_request_setup_inst (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .start                   (start),
    .base_addr               (base_addr),
    .num_txn                 (num_txn),
    .final_len               (final_len),
    .single_txn              (single_txn)
  );

  ar_issue ar_issue_inst (
    .aclk       (aclk),
    .areset     (areset),
    .start      (start),
    .base_addr  (base_addr),
    .num_txn    (num_txn),
    .final_len  (final_len),
    .single_txn (single_txn),
    .burst_done (burst_done),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .arlen      (arlen)
  );

  //////////////////////////////
  // Data path
  //////////////////////////////

  rd_data_fifo rd_data_fifo_inst (
    .aclk   (aclk),
    .areset (areset),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rlast  (rlast),
    .tvalid (tvalid),
    .tready (tready),
    .tdata  (tdata),
    .tlast  (tlast)
  );

  // Watches the stream, not the read channel
  rd_completion rd_completion_inst (
    .aclk       (aclk),
    .areset     (areset),
    .start      (start),
    .num_txn    (num_txn),
    .tvalid     (tvalid),
    .tready     (tready),
    .tlast      (tlast),
    .burst_done (burst_done),
    .ctrl_done  (ctrl_done)
  );

endmodule

/* logic/rd_completion.sv */
// Stream-side burst completion count and transfer done pulse
module rd_completion
  import rd_master_pkg::*;
(
  input  logic       aclk,
  input  logic       areset,
  input  logic       start,
  input  txn_count_t num_txn,
  input  logic       tvalid,
  input  logic       tready,
  input  logic       tlast,
  output logic       burst_done,
  output logic       ctrl_done
);

  logic       active;
  logic       final_burst;

  //////////////////////////////
  // Burst tracking
  //////////////////////////////

  // Last beat of a burst leaves the FIFO
  assign burst_done = tvalid & tready & tlast;

  // Bursts left on the stream side, zero while the final one drains
  xfer_counter #(
    .width      (txn_cntr_w),
    .init_value ('0)
  ) burst_cntr_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (burst_done),
    .load_value (num_txn),
    .count      (),
    .is_zero    (final_burst)
  );

  //////////////////////////////
  // Done
  //////////////////////////////

  // Open from start until done
  always_ff @(posedge aclk) begin
    if (areset) begin
      active <= 1'b0;
    end else if (start) begin
      active <= 1'b1;
    end else if (ctrl_done) begin
      active <= 1'b0;
    end
  end

  // Same cycle as the final tlast handshake
  assign ctrl_done = burst_done & final_burst & active;

endmodule

/* logic/rd_data_fifo.sv */
// First-word-fall-through data FIFO from read data channel to output stream
module rd_data_fifo
  import rd_master_pkg::*;
(
  input  logic  aclk,
  input  logic  areset,
  input  logic  rvalid,
  output logic  rready,
  input  data_t rdata,
  input  logic  rlast,
  output logic  tvalid,
  input  logic  tready,
  output data_t tdata,
  output logic  tlast
);

  // Each entry is the last flag above the data word
  logic [data_w:0]        mem [fifo_depth];

  logic [fifo_addr_w-1:0] wr_ptr;
  logic [fifo_addr_w-1:0] rd_ptr;
  // One extra bit to tell full from empty
  logic [fifo_addr_w:0]   occupancy;

  logic                   full;
  logic                   push;
  logic                   pop;

  //////////////////////////////
  // Status
  //////////////////////////////

  assign full   = (occupancy == (fifo_addr_w + 1)'(fifo_depth));
  assign tvalid = (occupancy != '0);

  // Outstanding limit keeps this high in normal use
  assign rready = ~full;

  assign push = rvalid & rready;
  assign pop  = tvalid & tready;

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= {rlast, rdata};
    end
  end

  // Head entry shows without a read request
  assign {tlast, tdata} = mem[rd_ptr];

  //////////////////////////////
  // Pointers
  //////////////////////////////

  // Depth is a power of two, pointers simply wrap
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + fifo_addr_w'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + fifo_addr_w'(1);
      end
    end
  end

  // Push and pop together leave the level alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      occupancy <= '0;
    end else if (push && !pop) begin
      occupancy <= occupancy + 1'b1;
    end else if (pop && !push) begin
      occupancy <= occupancy - 1'b1;
    end
  end

endmodule

/* logic/rd_master_pkg.sv */
// Read master widths, burst limits, FIFO sizing and shared vector types
package rd_master_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int addr_w       = 32;
  localparam int data_w       = 32;
  localparam int dw_bytes     = data_w / 8;
  localparam int log_dw_bytes = $clog2(dw_bytes);

  // Byte count on the control port
  localparam int xfer_size_w = 20;

  //////////////////////////////
  // Burst limits
  //////////////////////////////

  // Protocol caps a burst at 256 beats and 4 KB, whichever is smaller
  localparam int max_burst_beats = 256;
  localparam int max_burst_bytes = 4096;
  localparam int burst_len       = (max_burst_bytes / dw_bytes < max_burst_beats) ?
                                   max_burst_bytes / dw_bytes : max_burst_beats;
  localparam int log_burst_len   = $clog2(burst_len);
  localparam int burst_bytes     = burst_len * dw_bytes;

  // Bursts allowed in flight, and the vacancy counter that tracks them
  localparam int max_outstanding = 4;
  localparam int outstanding_w   = $clog2(max_outstanding + 1);

  // Words per transfer, then bursts per transfer
  localparam int total_len_w = xfer_size_w - log_dw_bytes;
  localparam int txn_cntr_w  = total_len_w - log_burst_len;

  //////////////////////////////
  // Data FIFO
  //////////////////////////////

  // Room for every outstanding burst, rounded to a power of two
  localparam int fifo_depth  = 2 ** $clog2(burst_len * max_outstanding);
  localparam int fifo_addr_w = $clog2(fifo_depth);

  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [data_w-1:0]     data_t;
  typedef logic [txn_cntr_w-1:0] txn_count_t;
  // Beats in a burst minus one
  typedef logic [7:0]            arlen_t;

endpackage

/* logic/rd_request_setup.sv */
// Transfer request capture, word rounding, burst split and start strobe
module rd_request_setup
  import rd_master_pkg::*;
(
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  addr_t                  ctrl_addr_offset,
  input  logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes,
  output logic                   start,
  output addr_t                  base_addr,
  output txn_count_t             num_txn,
  output arlen_t                 final_len,
  output logic                   single_txn
);

  // Stage one results
  logic [total_len_w-1:0] total_len_r;
  logic                   start_d1;

  // Split of the word count
  txn_count_t             num_full_bursts;
  logic                   has_partial;

  //////////////////////////////
  // Strobe pipeline
  //////////////////////////////

  // Start follows the data through both stages
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  //////////////////////////////
  // Stage one
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole words
      if (ctrl_xfer_size_in_bytes[log_dw_bytes-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size_in_bytes[log_dw_bytes +: total_len_w] +
                       total_len_w'(1);
      end else begin
        total_len_r <= ctrl_xfer_size_in_bytes[log_dw_bytes +: total_len_w];
      end
      // Burst boundary alignment, low bits dropped
      base_addr <= ctrl_addr_offset & ~addr_t'(burst_bytes - 1);
    end
  end

  //////////////////////////////
  // Stage two
  //////////////////////////////

  // Upper bits count full bursts, lower bits the leftover words
  assign num_full_bursts = total_len_r[log_burst_len +: txn_cntr_w];
  assign has_partial     = (total_len_r[log_burst_len-1:0] != '0);

  always_ff @(posedge aclk) begin
    if (start_d1) begin
      // Bursts minus one
      // A leftover adds its own burst
      num_txn   <= has_partial ? num_full_bursts :
                                 num_full_bursts - txn_count_t'(1);
      // Zero leftover wraps to a full 255
      final_len <= arlen_t'(total_len_r[log_burst_len-1:0] - 1'b1);
    end
  end

  // One burst covers the whole transfer
  assign single_txn = (num_txn == '0);

endmodule

/* logic/xfer_counter.sv */
// Loadable up/down counter with zero flag for burst and vacancy counts
module xfer_counter
  import rd_master_pkg::*;
#(
  parameter int               width      = txn_cntr_w,
  parameter logic [width-1:0] init_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  //////////////////////////////
  // Count register
  //////////////////////////////

  // Load wins over counting
  // Simultaneous incr and decr cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init_value;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + width'(1);
    end else if (decr && !incr) begin
      count <= count - width'(1);
    end
  end

  //////////////////////////////
  // Flags
  //////////////////////////////

  // Straight from the register, no extra cycle
  assign is_zero = (count == '0);

endmodule

/* project.f */
logic/rd_master_pkg.sv
logic/xfer_counter.sv
logic/rd_request_setup.sv
logic/ar_issue.sv
logic/rd_data_fifo.sv
logic/rd_completion.sv
logic/axi_read_master.sv
bench/axi_read_master_chk.sv
bench/axi_read_master_tb.sv
